//--- Makefile
# Verilator build and run for the cache tag controller

VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = tb_cache_tag_ctrl
FILELIST = src.f
OBJ_DIR = obj_dir
LOG = sim.log
FAIL_MSG = === FAIL ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/cache_lru.sv
`default_nettype none

// Tree pseudo-LRU replacement state for every set.
//
// Each set holds three bits that describe a binary tree over the ways.
// Bit 1 is the root and picks the half, 0 for ways 0..1 and 1 for ways 2..3.
// Bit 2 picks within the low half, 0 for way 0 and 1 for way 1.
// Bit 0 picks within the high half, 0 for way 2 and 1 for way 3.
// The bits always point toward the least recently used way.
//
// The set is presented in one cycle and the LRU way is valid the next.
// An update in that next cycle applies to the same set.
module cache_lru
(
	input wire clk,
	input wire reset,
	input wire [cache_pkg::set_width-1:0] set_i,
	input wire update_i,
	input wire [cache_pkg::way_width-1:0] new_mru_way_i,
	output logic [cache_pkg::way_width-1:0] lru_way_o
);

	import cache_pkg::*;

	logic [lru_bits-1:0] old_bits;
	logic [lru_bits-1:0] new_bits;
	logic [set_width-1:0] set_latched;

	// State RAM, read every cycle and written back for the previous set
	sram_1r1w #(
		.data_width(lru_bits),
		.size(num_sets),
		.addr_width(set_width)
	) lru_ram (
		.clk(clk),
		.rd_enable_i(1'b1),
		.rd_addr_i(set_i),
		.rd_data_o(old_bits),
		.wr_enable_i(update_i),
		.wr_addr_i(set_latched),
		.wr_data_i(new_bits)
	);

	// Remember which set the read data belongs to
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			set_latched <= '0;
		else
			set_latched <= set_i;
	end

	// Follow the tree from the root down to the LRU leaf
	always_comb
	begin
		if (!old_bits[1])
			lru_way_o = old_bits[2] ? 2'd1 : 2'd0;
		else
			lru_way_o = old_bits[0] ? 2'd3 : 2'd2;
	end

	// Turn the nodes on the MRU path away from it
	// The node of the other half is left as it was
	always_comb
	begin
		case (new_mru_way_i)
			2'd0: new_bits = {2'b11, old_bits[0]};
			2'd1: new_bits = {2'b01, old_bits[0]};
			2'd2: new_bits = {old_bits[2], 2'b01};
			default: new_bits = {old_bits[2], 2'b00};
		endcase
	end

endmodule

`default_nettype wire

//--- source/cache_pkg.sv
`default_nettype none

// Geometry of the 4-way set-associative tag store.
// Every width below is derived from a count, so keep them in step.
package cache_pkg;

	// Number of ways in each set
	localparam int num_ways = 4;

	// Bits needed to name one way
	localparam int way_width = 2;

	// Number of sets, selected by the low index bits of an address
	localparam int num_sets = 32;

	// Bits needed to name one set
	localparam int set_width = 5;

	// Width of the stored tag
	localparam int tag_width = 8;

	// Tree pseudo-LRU state per set, one bit per internal node
	localparam int lru_bits = 3;

endpackage

`default_nettype wire

//--- source/cache_tag_array.sv
`default_nettype none

// Tag storage and lookup for all ways.
//
// Tags live in one RAM per way, valid bits in flops so that reset can
// clear them. The set and tag are presented in one cycle; hit, valid and
// victim results are available combinationally in the next.
// A fill in that next cycle writes the latched tag into the latched set.
module cache_tag_array
(
	input wire clk,
	input wire reset,
	input wire [cache_pkg::set_width-1:0] set_i,
	input wire [cache_pkg::tag_width-1:0] tag_i,
	input wire [cache_pkg::way_width-1:0] victim_way_i,
	input wire fill_i,
	input wire [cache_pkg::way_width-1:0] fill_way_i,
	output logic hit_o,
	output logic [cache_pkg::way_width-1:0] hit_way_o,
	output logic [cache_pkg::num_ways-1:0] valid_o,
	output logic [cache_pkg::tag_width-1:0] victim_tag_o,
	output logic victim_valid_o
);

	import cache_pkg::*;

	logic [set_width-1:0] set_latched;
	logic [tag_width-1:0] tag_latched;
	logic [tag_width-1:0] tag_rd [num_ways];
	logic [num_sets-1:0][num_ways-1:0] valid_bits;
	logic [num_ways-1:0] fill_onehot;
	logic [num_ways-1:0] fwd_mask;
	logic [num_ways-1:0] hit_vec;

	// One-hot write strobe for the way being filled
	assign fill_onehot = fill_i ? (num_ways'(1) << fill_way_i) : '0;

	// A fill to the set being read right now must show up in the read
	assign fwd_mask = (set_latched == set_i) ? fill_onehot : '0;

	for (genvar w = 0; w < num_ways; w++)
	begin : gen_way
		sram_1r1w #(
			.data_width(tag_width),
			.size(num_sets),
			.addr_width(set_width)
		) tag_ram (
			.clk(clk),
			.rd_enable_i(1'b1),
			.rd_addr_i(set_i),
			.rd_data_o(tag_rd[w]),
			.wr_enable_i(fill_onehot[w]),
			.wr_addr_i(set_latched),
			.wr_data_i(tag_latched)
		);

		// Only a valid way with a matching tag counts as a hit
		assign hit_vec[w] = valid_o[w] && tag_rd[w] == tag_latched;
	end

	// Set index is control state for the write port
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			set_latched <= '0;
			valid_o <= '0;
			valid_bits <= '0;
		end
		else
		begin
			set_latched <= set_i;
			valid_o <= valid_bits[set_i] | fwd_mask;
			if (fill_i)
				valid_bits[set_latched] <= valid_bits[set_latched] | fill_onehot;
		end
	end

	// Tag to be written on a miss, one cycle behind the lookup
	always_ff @(posedge clk)
		tag_latched <= tag_i;

	// Encode the matching way; at most one way can match
	always_comb
	begin
		hit_way_o = '0;
		for (int w = 0; w < num_ways; w++)
		begin
			if (hit_vec[w])
				hit_way_o = way_width'(w);
		end
	end

	assign hit_o = |hit_vec;

	// Line that would be displaced by a fill into the victim way
	assign victim_tag_o = tag_rd[victim_way_i];
	assign victim_valid_o = valid_o[victim_way_i];

endmodule

`default_nettype wire

//--- source/cache_tag_ctrl.sv
`default_nettype none

// Top of the tag and replacement subsystem.
//
// A request in cycle N is answered in cycle N+1. A hit makes the hit way
// most recently used. A miss allocates at once; it fills the lowest
// invalid way, or the pseudo-LRU way when the set is full, and reports
// the tag it pushed out. Requests may arrive every cycle.
module cache_tag_ctrl
(
	input wire clk,
	input wire reset,
	input wire access_i,
	input wire [cache_pkg::set_width-1:0] set_i,
	input wire [cache_pkg::tag_width-1:0] tag_i,
	output logic result_valid_o,
	output logic hit_o,
	output logic [cache_pkg::way_width-1:0] way_o,
	output logic evict_o,
	output logic [cache_pkg::tag_width-1:0] evict_tag_o
);

	import cache_pkg::*;

	logic [way_width-1:0] lru_way;
	logic [way_width-1:0] alloc_way;
	logic [way_width-1:0] hit_way;
	logic [num_ways-1:0] valid_rd;
	logic tag_hit;
	logic victim_valid;
	logic fill;

	// Set and tag of the request stage are held inside the arrays;
	// only the strobe needs a stage register here
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			result_valid_o <= 1'b0;
		else
			result_valid_o <= access_i;
	end

	cache_lru lru (
		.clk(clk),
		.reset(reset),
		.set_i(set_i),
		.update_i(result_valid_o),
		.new_mru_way_i(way_o),
		.lru_way_o(lru_way)
	);

	cache_tag_array tags (
		.clk(clk),
		.reset(reset),
		.set_i(set_i),
		.tag_i(tag_i),
		.victim_way_i(alloc_way),
		.fill_i(fill),
		.fill_way_i(way_o),
		.hit_o(tag_hit),
		.hit_way_o(hit_way),
		.valid_o(valid_rd),
		.victim_tag_o(evict_tag_o),
		.victim_valid_o(victim_valid)
	);

	// Prefer an empty way, lowest index first, before disturbing the LRU line
	always_comb
	begin
		alloc_way = lru_way;
		for (int w = num_ways - 1; w >= 0; w--)
		begin
			if (!valid_rd[w])
				alloc_way = way_width'(w);
		end
	end

	assign hit_o = result_valid_o && tag_hit;
	assign fill = result_valid_o && !tag_hit;
	assign way_o = tag_hit ? hit_way : alloc_way;

	// Eviction only when the allocated way already held a line
	assign evict_o = fill && victim_valid;

endmodule

`default_nettype wire

//--- source/sram_1r1w.sv
`default_nettype none

// Simple dual-port RAM with one read port and one write port.
// The read is registered, so data appears the cycle after the address.
// When a read and a write hit the same address on one edge, the read
// returns the new data rather than the stale stored word.
module sram_1r1w
#(
	parameter int data_width = 8,
	parameter int size = 32,
	parameter int addr_width = 5
)
(
	input wire clk,
	input wire rd_enable_i,
	input wire [addr_width-1:0] rd_addr_i,
	output logic [data_width-1:0] rd_data_o,
	input wire wr_enable_i,
	input wire [addr_width-1:0] wr_addr_i,
	input wire [data_width-1:0] wr_data_i
);

	// Storage array, contents are undefined until first written
	logic [data_width-1:0] mem [0:size-1];

	always_ff @(posedge clk)
	begin
		if (wr_enable_i)
			mem[wr_addr_i] <= wr_data_i;

		if (rd_enable_i)
		begin
			// Forward the word being written this cycle to the reader
			if (wr_enable_i && wr_addr_i == rd_addr_i)
				rd_data_o <= wr_data_i;
			else
				rd_data_o <= mem[rd_addr_i];
		end
	end

endmodule

`default_nettype wire

//--- src.f
source/cache_pkg.sv
source/sram_1r1w.sv
source/cache_lru.sv
source/cache_tag_array.sv
source/cache_tag_ctrl.sv
testbench/cache_tag_ctrl_properties.sv
testbench/tb_cache_tag_ctrl.sv

//--- testbench/cache_tag_ctrl_properties.sv
`default_nettype none

// Cycle rules of the tag controller's result port
module cache_tag_ctrl_properties
(
	input wire clk,
	input wire reset,
	input wire access_i,
	input wire result_valid_o,
	input wire hit_o,
	input wire evict_o
);

	// Every request is answered exactly one cycle later
	result_follows_access: assert property (@(posedge clk) disable iff (reset)
		result_valid_o == $past(access_i))
		else $error("result_valid_o does not follow access_i by one cycle");

	// A hit never displaces a line
	hit_not_evict: assert property (@(posedge clk) disable iff (reset)
		!(hit_o && evict_o))
		else $error("hit_o and evict_o are high together");

	// Without a result there is nothing to report
	quiet_without_result: assert property (@(posedge clk) disable iff (reset)
		!result_valid_o |-> (!hit_o && !evict_o))
		else $error("hit_o or evict_o is high while result_valid_o is low");

endmodule

bind cache_tag_ctrl cache_tag_ctrl_properties props (
	.clk(clk),
	.reset(reset),
	.access_i(access_i),
	.result_valid_o(result_valid_o),
	.hit_o(hit_o),
	.evict_o(evict_o)
);

`default_nettype wire

//--- testbench/tb_cache_tag_ctrl.sv
`default_nettype none

// Testbench for the cache tag controller.
// A reference model holds tags, valid bits and tree bits per set and
// predicts every result one cycle after its request.
module tb_cache_tag_ctrl;

	import cache_pkg::*;

	localparam int period = 4;
	localparam int random_cycles = 400;
	// Reset, the five tests and their drain cycles
	localparam int total_cycles = 4 + 20 + 16 + 16 + 24 + random_cycles + 5 * 2;
	localparam int margin_cycles = 100;

	logic clk;
	logic reset;
	logic access_i;
	logic [set_width-1:0] set_i;
	logic [tag_width-1:0] tag_i;
	logic result_valid_o;
	logic hit_o;
	logic [way_width-1:0] way_o;
	logic evict_o;
	logic [tag_width-1:0] evict_tag_o;

	integer seed;
	int errors;
	int checks;
	int failed_tests;
	int test_start_errors;

	// Model state per set and way
	logic [tag_width-1:0] model_tag [num_sets][num_ways];
	bit model_valid [num_sets][num_ways];
	// Fills per set, the tree is only fully written after four of them
	int model_fills [num_sets];
	// Tree nodes, root picks the half and the others pick within a half
	bit tree_root [num_sets];
	bit tree_low [num_sets];
	bit tree_high [num_sets];

	// Request seen at the previous falling edge
	bit prev_access;
	int prev_set;
	logic [tag_width-1:0] prev_tag;

	cache_tag_ctrl dut (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.set_i(set_i),
		.tag_i(tag_i),
		.result_valid_o(result_valid_o),
		.hit_o(hit_o),
		.way_o(way_o),
		.evict_o(evict_o),
		.evict_tag_o(evict_tag_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Ends a run that stalls past the expected number of cycles
	initial
	begin
		#((total_cycles + margin_cycles) * period);
		$display("Timeout: the tests did not finish within %0d cycles",
			total_cycles + margin_cycles);
		$display("=== FAIL ===");
		$finish;
	end

	function automatic int rand_below(int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fffffff) % n;
	endfunction

	// Walk the tree toward the least recently used leaf
	function automatic int plru_way(int s);
		if (!tree_root[s])
			return tree_low[s] ? 1 : 0;
		return tree_high[s] ? 3 : 2;
	endfunction

	// Point the nodes on the path of way w away from it
	task automatic touch_way(int s, int w);
		if (w < 2)
		begin
			tree_root[s] = 1'b1;
			tree_low[s] = (w == 0);
		end
		else
		begin
			tree_root[s] = 1'b0;
			tree_high[s] = (w == 2);
		end
	endtask

	task automatic issue(bit acc, int s, int t);
		@(posedge clk);
		access_i <= acc;
		set_i <= set_width'(s);
		tag_i <= tag_width'(t);
	endtask

	task automatic start_test();
		test_start_errors = errors;
	endtask

	// Two idle cycles let the last result reach the checker
	task automatic finish_test(int num, string name);
		int test_errors;
		issue(1'b0, 0, 0);
		issue(1'b0, 0, 0);
		test_errors = errors - test_start_errors;
		if (test_errors != 0)
			failed_tests++;
		$display("Test %0d %s: %s, %0d errors", num, name,
			test_errors == 0 ? "ok" : "failed", test_errors);
	endtask

	// Predict the result of the previous request and compare
	task automatic check_result();
		bit exp_hit;
		bit exp_evict;
		int exp_way;
		logic [tag_width-1:0] exp_evict_tag;
		int s;
		exp_hit = 1'b0;
		exp_evict = 1'b0;
		exp_way = 0;
		exp_evict_tag = '0;
		s = prev_set;
		checks++;
		assert (result_valid_o == prev_access)
		else
		begin
			$display("Mismatch at %0t: result_valid_o is %b, expected %b",
				$time, result_valid_o, prev_access);
			errors++;
		end
		if (!prev_access)
		begin
			assert (!hit_o && !evict_o)
			else
			begin
				$display("Mismatch at %0t: hit_o or evict_o high without a result", $time);
				errors++;
			end
		end
		else
		begin
			for (int w = 0; w < num_ways; w++)
			begin
				if (model_valid[s][w] && model_tag[s][w] == prev_tag)
				begin
					exp_hit = 1'b1;
					exp_way = w;
				end
			end
			if (!exp_hit && model_fills[s] == num_ways)
			begin
				// Full set, replace the pseudo-LRU way
				exp_way = plru_way(s);
				exp_evict = 1'b1;
				exp_evict_tag = model_tag[s][exp_way];
			end
			else if (!exp_hit)
			begin
				for (int w = num_ways - 1; w >= 0; w--)
				begin
					if (!model_valid[s][w])
						exp_way = w;
				end
			end
			assert (hit_o == exp_hit && way_o == way_width'(exp_way))
			else
			begin
				$display("Mismatch at %0t: set %0d tag %0d gave hit %b way %0d, expected hit %b way %0d",
					$time, s, prev_tag, hit_o, way_o, exp_hit, exp_way);
				errors++;
			end
			assert (evict_o == exp_evict && (!exp_evict || evict_tag_o == exp_evict_tag))
			else
			begin
				$display("Mismatch at %0t: set %0d gave evict %b tag %0d, expected evict %b tag %0d",
					$time, s, evict_o, evict_tag_o, exp_evict, exp_evict_tag);
				errors++;
			end
			if (!exp_hit)
			begin
				model_tag[s][exp_way] = prev_tag;
				model_valid[s][exp_way] = 1'b1;
				if (model_fills[s] < num_ways)
					model_fills[s]++;
			end
			touch_way(s, exp_way);
		end
	endtask

	// Outputs are settled at the falling edge, inputs too
	always @(negedge clk)
	begin
		if (!reset)
			check_result();
		prev_access = access_i;
		prev_set = int'(set_i);
		prev_tag = tag_i;
	end

	initial
	begin
		seed = 32'h814d5cc4;
		errors = 0;
		checks = 0;
		failed_tests = 0;
		prev_access = 1'b0;
		for (int s = 0; s < num_sets; s++)
			model_fills[s] = 0;
		reset <= 1'b1;
		access_i <= 1'b0;
		set_i <= '0;
		tag_i <= '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// Empty sets fill their ways in order without eviction
		start_test();
		for (int s = 0; s < 4; s++)
		begin
			for (int t = 0; t < num_ways; t++)
				issue(1'b1, s, t);
			issue(1'b0, 0, 0);
		end
		finish_test(1, "fills of empty sets");

		// Stored tags come back as hits
		start_test();
		for (int i = 0; i < 16; i++)
			issue(1'b1, rand_below(4), rand_below(num_ways));
		finish_test(2, "hits on stored tags");

		// New tags in full sets push out the pseudo-LRU line
		start_test();
		for (int i = 0; i < 16; i++)
			issue(1'b1, i % 4, 8 + i);
		finish_test(3, "evictions from full sets");

		// One set every cycle, each access sees the previous update
		start_test();
		for (int t = 0; t < num_ways; t++)
			issue(1'b1, 8, t);
		for (int i = 0; i < 20; i++)
			issue(1'b1, 8, rand_below(6));
		finish_test(4, "back-to-back same set");

		start_test();
		for (int i = 0; i < random_cycles; i++)
			issue(rand_below(4) != 0, rand_below(8), rand_below(8));
		finish_test(5, "random mixed traffic");

		$display("Summary: %0d checks, %0d errors, %0d of 5 tests failed",
			checks, errors, failed_tests);
		if (errors == 0)
		begin
			$display("=== PASS ===");
		end
		else
		begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
